/* src/msx_glue_pkg.sv */
// Shared bus types and map constants; SDRAM address in 8 KB blocks, upper ten bits select region
`default_nettype none

package msx_glue_pkg;

	// ------------------------------
	//	Sizes
	// ------------------------------
	localparam int SDRAM_AW		= 23;				// SDRAM byte address width
	localparam int MAP_BW		= SDRAM_AW - 13;	// Region bits above the 8 KB block
	localparam int CPU_DIV		= 6;				// clk42m cycles per CPU enable

	// ------------------------------
	//	I/O ports
	// ------------------------------
	localparam logic [7:0] PPI_PORT		= 8'hA8;	// A8h-ABh
	localparam logic [7:0] PSG_PORT		= 8'hA0;	// A0h-A3h
	localparam logic [7:0] VDP_PORT		= 8'h98;	// 98h-99h
	localparam logic [7:0] KANJI_PORT	= 8'hD8;	// D8h-DBh

	// ------------------------------
	//	SDRAM region bases
	// ------------------------------
	// Upper ten address bits, the page bits are ORed in below them
	localparam logic [MAP_BW-1:0] MAP_NEXTOR	= 10'h000;	// 64 KB, banks 0-7
	localparam logic [MAP_BW-1:0] MAP_SUBROM	= 10'h008;	// 16 KB
	localparam logic [MAP_BW-1:0] MAP_MAIN		= 10'h010;	// 32 KB main ROM
	localparam logic [MAP_BW-1:0] MAP_KBASIC	= 10'h014;	// 32 KB kanji BASIC
	localparam logic [MAP_BW-1:0] MAP_BASICN	= 10'h018;	// 16 KB
	localparam logic [MAP_BW-1:0] MAP_MUSIC		= 10'h01A;	// 16 KB
	localparam logic [MAP_BW-1:0] MAP_LOGO		= 10'h01C;	// Logo plus ext BASIC, 32 KB
	localparam logic [MAP_BW-1:0] MAP_KANJI		= 10'h020;	// JIS1/JIS2 font, 256 KB
	localparam logic [MAP_BW-1:0] MAP_MEGA2		= 10'h080;	// 1 MB
	localparam logic [MAP_BW-1:0] MAP_MEGA1		= 10'h100;	// 2 MB
	localparam logic [MAP_BW-1:0] MAP_MAPPER	= 10'h200;	// 4 MB mapper RAM

	localparam logic [7:0] IDLE_BYTE	= 8'hFF;	// Floating data bus

	// ------------------------------
	//	Bus structs
	// ------------------------------
	typedef struct packed {
		logic	[15:0]	addr;
		logic	[7:0]	wdata;
		logic			mreq_n;
		logic			iorq_n;
		logic			rd_n;
		logic			wr_n;
	} cpu_bus_t;

	// Primary and expanded slot selects, active high
	typedef struct packed {
		logic			sltsl0;
		logic			sltsl1;
		logic			sltsl2;
		logic			sltsl3;
		logic			sltsl00;
		logic			sltsl01;
		logic			sltsl02;
		logic			sltsl03;
		logic			sltsl30;
		logic			sltsl31;
		logic			sltsl32;
		logic			sltsl33;
		logic	[1:0]	page;		// CPU page of the decoded access
	} slot_sel_t;

	typedef struct packed {
		logic	[21:0]	megarom1_addr;
		logic			megarom1_cs_n;
		logic			megarom1_rd_n;
		logic	[21:0]	megarom2_addr;
		logic			megarom2_cs_n;
		logic			megarom2_rd_n;
		logic	[17:0]	kanji_addr;
		logic			kanji_en;
		logic	[7:0]	mapper_segment;
	} rom_bank_t;

	// Loader write from SPI
	typedef struct packed {
		logic	[SDRAM_AW-1:0]	addr;
		logic	[7:0]			wdata;
		logic					mreq_n;
	} spi_req_t;

	typedef struct packed {
		logic	[SDRAM_AW-1:0]	addr;
		logic	[7:0]			wdata;
		logic					mreq_n;
		logic					rd_n;
		logic					wr_n;
	} sdram_req_t;

	typedef struct packed {
		logic			ppi_cs_n;
		logic			psg_cs_n;
		logic			vdp_cs_n;
		logic			kanji_cs_n;
	} io_cs_t;

	typedef struct packed {
		logic	[7:0]	data;
		logic			en;		// One-cycle valid
	} rd_byte_t;

	// Highest priority first
	typedef struct packed {
		rd_byte_t		sdram;
		rd_byte_t		vdp;
		rd_byte_t		expslt0;
		rd_byte_t		expslt3;
		rd_byte_t		ppi;
		rd_byte_t		psg;
	} rd_src_t;

endpackage

`default_nettype wire

/* src/msx_bus_control.sv */
// CPU enable every 6 clk42m cycles, stopped by freeze and SDRAM init; I/O selects are combinational
`timescale 1ns/100ps
`default_nettype none

module msx_bus_control (
	input	wire						clk42m,
	input	wire						ff_reset0_n,		// Sync, active low
	input	msx_glue_pkg::cpu_bus_t		cpu_bus,
	input	wire						cpu_freeze,
	input	wire						sdram_init_busy,
	output	logic						half_enable,		// 21 MHz rate pulse
	output	logic						cpu_enable,			// CPU and PSG step
	output	msx_glue_pkg::io_cs_t		io_cs
);

	localparam logic [2:0] DIV_LAST = 3'(msx_glue_pkg::CPU_DIV - 1);

	logic				ff_half;
	logic	[2:0]		ff_cpu_div;
	logic	[7:0]		w_port;

	// ------------------------------
	//	Clock enables
	// ------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_half <= 1'b0;
		end else begin
			ff_half <= ~ff_half;				// Half rate toggle
		end
	end

	assign half_enable = ff_half;

	// Modulo-6 counter, held at zero while frozen
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_cpu_div <= 3'd0;
		end else if (cpu_freeze) begin
			ff_cpu_div <= 3'd0;					// Restart cadence on release
		end else if (ff_cpu_div == DIV_LAST) begin
			ff_cpu_div <= 3'd0;
		end else begin
			ff_cpu_div <= ff_cpu_div + 3'd1;
		end
	end

	// Pulse on last count only
	assign cpu_enable = (ff_cpu_div == DIV_LAST) && !sdram_init_busy && !cpu_freeze;

	// ------------------------------
	//	I/O chip selects
	// ------------------------------
	assign w_port = cpu_bus.addr[7:0];			// Z80 I/O uses low byte

	// Four ports each, VDP has two
	always_comb begin
		io_cs.ppi_cs_n		= 1'b1;
		io_cs.psg_cs_n		= 1'b1;
		io_cs.vdp_cs_n		= 1'b1;
		io_cs.kanji_cs_n	= 1'b1;
		if (!cpu_bus.iorq_n) begin
			if ({w_port[7:2], 2'b00} == msx_glue_pkg::PPI_PORT) begin
				io_cs.ppi_cs_n = 1'b0;
			end
			if ({w_port[7:2], 2'b00} == msx_glue_pkg::PSG_PORT) begin
				io_cs.psg_cs_n = 1'b0;
			end
			if ({w_port[7:1], 1'b0} == msx_glue_pkg::VDP_PORT) begin
				io_cs.vdp_cs_n = 1'b0;			// 98h data, 99h control
			end
			if ({w_port[7:2], 2'b00} == msx_glue_pkg::KANJI_PORT) begin
				io_cs.kanji_cs_n = 1'b0;		// JIS1 and JIS2 address ports
			end
		end
	end

endmodule

`default_nettype wire

/* src/msx_memory_map.sv */
// SDRAM request registered one cycle after the bus; ROM windows use slot_sel.page, RAM only in slot 3-0
`timescale 1ns/100ps
`default_nettype none

module msx_memory_map (
	input	wire						clk42m,
	input	wire						ff_reset0_n,
	input	msx_glue_pkg::cpu_bus_t		cpu_bus,
	input	msx_glue_pkg::slot_sel_t	slot_sel,
	input	msx_glue_pkg::rom_bank_t	rom_bank,
	input	msx_glue_pkg::spi_req_t		spi_req,
	input	wire						cpu_freeze,			// Loader owns SDRAM
	output	msx_glue_pkg::sdram_req_t	sdram_req
);

	localparam int AW = msx_glue_pkg::SDRAM_AW;
	localparam int BW = msx_glue_pkg::MAP_BW;

	logic	[BW-1:0]	w_hi;			// Region plus block
	logic	[12:0]		w_lo;			// Offset inside 8 KB block
	logic	[7:0]		w_wdata;
	logic				w_mreq_n;
	logic				w_rd_n;
	logic				w_wr_n;
	logic	[1:0]		w_page;
	logic	[15:0]		a;

	logic	[AW-1:0]	ff_addr;
	logic	[7:0]		ff_wdata;
	logic				ff_mreq_n;
	logic				ff_rd_n;
	logic				ff_wr_n;

	assign a		= cpu_bus.addr;
	assign w_page	= slot_sel.page;

	// ------------------------------
	//	Region select
	// ------------------------------
	always_comb begin
		if (cpu_freeze) begin
			w_hi = spi_req.addr[AW-1:13];					// Loader writes anywhere
		end else if (rom_bank.kanji_en) begin
			w_hi = msx_glue_pkg::MAP_KANJI | {5'd0, rom_bank.kanji_addr[17:13]};
		end else if (slot_sel.sltsl30) begin
			// 16 KB segment, a13 picks the half
			w_hi = msx_glue_pkg::MAP_MAPPER | {1'b0, rom_bank.mapper_segment, a[13]};
		end else if (slot_sel.sltsl1) begin
			w_hi = msx_glue_pkg::MAP_MEGA1 | {2'd0, rom_bank.megarom1_addr[20:13]};
		end else if (slot_sel.sltsl2) begin
			w_hi = msx_glue_pkg::MAP_MEGA2 | {3'd0, rom_bank.megarom2_addr[19:13]};
		end else if (slot_sel.sltsl03) begin
			w_hi = msx_glue_pkg::MAP_LOGO | {8'd0, a[14:13]};		// Logo, ext BASIC
		end else if (slot_sel.sltsl02) begin
			w_hi = msx_glue_pkg::MAP_MUSIC | {9'd0, a[13]};
		end else if (slot_sel.sltsl01) begin
			w_hi = msx_glue_pkg::MAP_BASICN | {9'd0, a[13]};
		end else if (slot_sel.sltsl31 && (w_page == 2'd0)) begin
			w_hi = msx_glue_pkg::MAP_SUBROM | {9'd0, a[13]};
		end else if (slot_sel.sltsl31) begin
			w_hi = msx_glue_pkg::MAP_KBASIC | {8'd0, a[15], a[13]};	// Pages 1-3 fold to 32 KB
		end else if (slot_sel.sltsl00) begin
			w_hi = msx_glue_pkg::MAP_MAIN | {8'd0, a[14:13]};
		end else if (slot_sel.sltsl32) begin
			w_hi = msx_glue_pkg::MAP_NEXTOR | {7'd0, a[15:13]};	// Bank 0-7
		end else begin
			w_hi = '0;										// Slot 3-3 empty
		end
	end

	// Block offset, same priority as above
	always_comb begin
		if (cpu_freeze) begin
			w_lo = spi_req.addr[12:0];
		end else if (rom_bank.kanji_en) begin
			w_lo = rom_bank.kanji_addr[12:0];
		end else begin
			w_lo = a[12:0];
		end
	end

	assign w_wdata	= cpu_freeze ? spi_req.wdata : cpu_bus.wdata;

	// ------------------------------
	//	Strobes
	// ------------------------------
	always_comb begin
		if (cpu_freeze) begin
			w_mreq_n	= spi_req.mreq_n;
			w_wr_n		= spi_req.mreq_n;					// Loader cycles are writes
		end else begin
			w_mreq_n	= rom_bank.kanji_en ? 1'b0 : cpu_bus.mreq_n;
			w_wr_n		= slot_sel.sltsl30 ? cpu_bus.wr_n : 1'b1;	// Only RAM is writable
		end
	end

	// rd_n passes inside valid pages only
	always_comb begin
		w_rd_n = 1'b1;
		if (cpu_freeze) begin
			w_rd_n = 1'b1;
		end else if (rom_bank.kanji_en) begin
			w_rd_n = 1'b0;									// Font fetch
		end else if (!cpu_bus.iorq_n) begin
			w_rd_n = 1'b1;									// I/O cycle
		end else if (slot_sel.sltsl30) begin
			w_rd_n = cpu_bus.rd_n;
		end else if (!rom_bank.megarom1_cs_n) begin
			w_rd_n = rom_bank.megarom1_rd_n;
		end else if (!rom_bank.megarom2_cs_n) begin
			w_rd_n = rom_bank.megarom2_rd_n;
		end else if (slot_sel.sltsl03 && (w_page == 2'd1 || w_page == 2'd2)) begin
			w_rd_n = cpu_bus.rd_n;
		end else if (slot_sel.sltsl02 && (w_page == 2'd1)) begin
			w_rd_n = cpu_bus.rd_n;
		end else if (slot_sel.sltsl01 && (w_page == 2'd1)) begin
			w_rd_n = cpu_bus.rd_n;
		end else if (slot_sel.sltsl31) begin
			w_rd_n = cpu_bus.rd_n;							// Sub-ROM and kanji BASIC
		end else if (slot_sel.sltsl00 && !w_page[1]) begin
			w_rd_n = cpu_bus.rd_n;							// Pages 0-1
		end else if (slot_sel.sltsl32 && (w_page == 2'd1 || w_page == 2'd2)) begin
			w_rd_n = cpu_bus.rd_n;
		end
	end

	// ------------------------------
	//	Request register
	// ------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_addr		<= '0;
			ff_mreq_n	<= 1'b1;
			ff_rd_n		<= 1'b1;
			ff_wr_n		<= 1'b1;
		end else begin
			ff_addr		<= {w_hi, w_lo};
			ff_mreq_n	<= w_mreq_n;
			ff_rd_n		<= w_rd_n;
			ff_wr_n		<= w_wr_n;
		end
	end

	always_ff @(posedge clk42m) begin
		ff_wdata <= w_wdata;
	end

	assign sdram_req = '{
		addr:	ff_addr,
		wdata:	ff_wdata,
		mreq_n:	ff_mreq_n,
		rd_n:	ff_rd_n,
		wr_n:	ff_wr_n
	};

endmodule

`default_nettype wire

/* src/msx_read_mux.sv */
// CPU read byte latched one cycle after a source enable; sources are assumed to pulse en for one cycle
`timescale 1ns/100ps
`default_nettype none

module msx_read_mux (
	input	wire						clk42m,
	input	wire						ff_reset0_n,
	input	msx_glue_pkg::rd_src_t		rd_src,
	input	wire						rd_n,			// CPU read strobe
	output	logic	[7:0]				cpu_rdata
);

	logic	[7:0]	ff_rdata;

	// ------------------------------
	//	Priority latch
	// ------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset0_n) begin
			ff_rdata <= msx_glue_pkg::IDLE_BYTE;
		end else if (rd_src.sdram.en) begin
			ff_rdata <= rd_src.sdram.data;			// Memory wins
		end else if (rd_src.vdp.en) begin
			ff_rdata <= rd_src.vdp.data;
		end else if (rd_src.expslt0.en) begin
			ff_rdata <= rd_src.expslt0.data;		// Slot 0 expansion register
		end else if (rd_src.expslt3.en) begin
			ff_rdata <= rd_src.expslt3.data;		// Slot 3 expansion register
		end else if (rd_src.ppi.en) begin
			ff_rdata <= rd_src.ppi.data;
		end else if (rd_src.psg.en) begin
			ff_rdata <= rd_src.psg.data;
		end else if (rd_n) begin
			// Bus idle reads as pulled up
			ff_rdata <= msx_glue_pkg::IDLE_BYTE;
		end
		// Read in progress, keep last byte
	end

	assign cpu_rdata = ff_rdata;

endmodule

`default_nettype wire

/* src/msx_glue_top.sv */
// Bus glue top on one clock clk42m; slot, bank and loader state come from outside cores
`timescale 1ns/100ps
`default_nettype none

module msx_glue_top (
	input	wire						clk42m,
	input	wire						ff_reset0_n,		// Sync, active low
	// CPU side
	input	msx_glue_pkg::cpu_bus_t		cpu_bus,
	input	msx_glue_pkg::slot_sel_t	slot_sel,
	input	msx_glue_pkg::rom_bank_t	rom_bank,
	// Loader
	input	msx_glue_pkg::spi_req_t		spi_req,
	input	wire						cpu_freeze,
	input	wire						sdram_init_busy,
	// Peripheral read bytes
	input	msx_glue_pkg::rd_src_t		rd_src,
	output	logic						cpu_enable,
	output	logic						half_enable,
	output	msx_glue_pkg::io_cs_t		io_cs,
	output	msx_glue_pkg::sdram_req_t	sdram_req,
	output	logic	[7:0]				cpu_rdata
);

	// ------------------------------
	//	Enables and I/O decode
	// ------------------------------
	msx_bus_control u_bus_control (
		.clk42m				( clk42m			),
		.ff_reset0_n		( ff_reset0_n		),
		.cpu_bus			( cpu_bus			),
		.cpu_freeze			( cpu_freeze		),
		.sdram_init_busy	( sdram_init_busy	),
		.half_enable		( half_enable		),
		.cpu_enable			( cpu_enable		),
		.io_cs				( io_cs				)
	);

	// SDRAM map
	msx_memory_map u_memory_map (
		.clk42m				( clk42m			),
		.ff_reset0_n		( ff_reset0_n		),
		.cpu_bus			( cpu_bus			),
		.slot_sel			( slot_sel			),
		.rom_bank			( rom_bank			),
		.spi_req			( spi_req			),
		.cpu_freeze			( cpu_freeze		),
		.sdram_req			( sdram_req			)
	);

	// ------------------------------
	//	CPU read data
	// ------------------------------
	msx_read_mux u_read_mux (
		.clk42m				( clk42m			),
		.ff_reset0_n		( ff_reset0_n		),
		.rd_src				( rd_src			),
		.rd_n				( cpu_bus.rd_n		),		// Idle fill when high
		.cpu_rdata			( cpu_rdata			)
	);

endmodule

`default_nettype wire

/* tests/msx_glue_assert.sv */
// Bound into msx_bus_control; checks assume a free running clk42m and synchronous reset
`timescale 1ns/100ps
`default_nettype none

module msx_glue_assert (
	input	wire					clk42m,
	input	wire					ff_reset0_n,
	input	wire					cpu_freeze,
	input	wire					sdram_init_busy,
	input	wire					cpu_enable,
	input	msx_glue_pkg::io_cs_t	io_cs
);

	int		fail_count = 0;		// Failed assertions so far

	// ------------------------------
	//	Enable rules
	// ------------------------------
	// Freeze clears the divider so the count restarts from zero
	enable_gated: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		cpu_freeze |=> !cpu_enable [*5])
		else begin
			$error("cpu_enable within 5 cycles of freeze");
			fail_count++;
		end

	// No pulse inside the divide window
	enable_spacing: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		cpu_enable |=> !cpu_enable [*5])
		else begin
			$error("cpu_enable pulses closer than 6 cycles");
			fail_count++;
		end

	// Free running cadence
	enable_period: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		(cpu_enable && !cpu_freeze && !sdram_init_busy)
			##1 (!cpu_freeze && !sdram_init_busy) [*6] |-> cpu_enable)
		else begin
			$error("cpu_enable missing 6 cycles after last pulse");
			fail_count++;
		end

	// ------------------------------
	//	I/O selects
	// ------------------------------
	cs_onehot: assert property (@(posedge clk42m) disable iff (!ff_reset0_n)
		$onehot0(~io_cs))
		else begin
			$error("more than one I/O chip select active");
			fail_count++;
		end

endmodule

bind msx_bus_control msx_glue_assert u_glue_assert (.*);

`default_nettype wire

/* tests/msx_glue_tb.sv */
// Directed tests on msx_glue_top, 100 ns clock; expected values rebuilt from the region table
`timescale 1ns/100ps
`default_nettype none

module msx_glue_tb;

	logic						clk42m;
	logic						ff_reset0_n;
	msx_glue_pkg::cpu_bus_t		cpu_bus;
	msx_glue_pkg::slot_sel_t	slot_sel;
	msx_glue_pkg::rom_bank_t	rom_bank;
	msx_glue_pkg::spi_req_t		spi_req;
	logic						cpu_freeze;
	logic						sdram_init_busy;
	msx_glue_pkg::rd_src_t		rd_src;
	logic						cpu_enable;
	logic						half_enable;
	msx_glue_pkg::io_cs_t		io_cs;
	msx_glue_pkg::sdram_req_t	sdram_req;
	logic	[7:0]				cpu_rdata;

	int				errors = 0;
	int				cycles = 0;
	logic	[19:0]	lfsr_state = 20'd78601;		// Seed

	msx_glue_top dut0 (.*);

	initial begin
		clk42m = 1'b0;
		forever #50 clk42m = ~clk42m;
	end

	// Timeout, about four times the test length
	always @(posedge clk42m) begin
		cycles <= cycles + 1;
		if (cycles >= 2000) begin
			$display("Timeout: run passed 2000 cycles");
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// x^20 + x^17 + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[18:0], lfsr_state[19] ^ lfsr_state[16]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		$display("Test %s: %0d errors", name, errors - err_start);
	endtask

	// ------------------------------
	//	Enable cadence
	// ------------------------------
	task automatic test_enables();
		int e0;
		int gap;
		logic prev_half;
		e0 = errors;
		@(negedge clk42m);
		while (!cpu_enable) @(negedge clk42m);
		prev_half = half_enable;
		for (int p = 0; p < 4; p++) begin
			gap = 0;
			do begin
				@(negedge clk42m);
				gap++;
				check_value("half_enable", half_enable, !prev_half);
				prev_half = half_enable;
			end while (!cpu_enable && gap < 20);
			check_value("cpu_enable gap", gap, 6);
		end
		// Freeze, then SDRAM init
		for (int k = 0; k < 2; k++) begin
			@(posedge clk42m);
			cpu_freeze <= (k == 0);
			sdram_init_busy <= (k == 1);
			repeat (15) begin
				@(negedge clk42m);
				check_value("cpu_enable while blocked", cpu_enable, 1'b0);
			end
			@(posedge clk42m);
			cpu_freeze <= 1'b0;
			sdram_init_busy <= 1'b0;
		end
		report_test("enables", e0);
	endtask

	// ------------------------------
	//	I/O decode
	// ------------------------------
	task automatic test_io_decode();
		int e0;
		logic [7:0] port;
		logic iorq_n;
		logic io_on;
		e0 = errors;
		for (int i = 0; i < 256; i++) begin
			port = i[7:0];
			iorq_n = 1'(rand_bits(1));
			@(posedge clk42m);
			cpu_bus <= '{addr: {8'(rand_bits(8)), port}, wdata: 8'h00, mreq_n: 1'b1,
				iorq_n: iorq_n, rd_n: 1'b0, wr_n: 1'b1};
			@(negedge clk42m);
			io_on = !iorq_n;
			check_value("ppi_cs_n", io_cs.ppi_cs_n, !(io_on && port >= 8'hA8 && port <= 8'hAB));
			check_value("psg_cs_n", io_cs.psg_cs_n, !(io_on && port >= 8'hA0 && port <= 8'hA3));
			check_value("vdp_cs_n", io_cs.vdp_cs_n, !(io_on && port >= 8'h98 && port <= 8'h99));
			check_value("kanji_cs_n", io_cs.kanji_cs_n,
				!(io_on && port >= 8'hD8 && port <= 8'hDB));
		end
		report_test("io_decode", e0);
	endtask

	// ------------------------------
	//	Memory map
	// ------------------------------
	// 0 RAM 3-0, 1 mega1, 2 mega2, 3 slot 0-3, 4 slot 0-2, 5 slot 0-1,
	// 6 slot 3-1, 7 slot 0-0, 8 slot 3-2, 9 slot 3-3 empty
	function automatic msx_glue_pkg::slot_sel_t make_sel(input int s, input logic [1:0] pg);
		msx_glue_pkg::slot_sel_t sel;
		sel = '0;
		sel.page = pg;
		case (s)
			0: sel.sltsl30 = 1'b1;
			1: sel.sltsl1 = 1'b1;
			2: sel.sltsl2 = 1'b1;
			3: sel.sltsl03 = 1'b1;
			4: sel.sltsl02 = 1'b1;
			5: sel.sltsl01 = 1'b1;
			6: sel.sltsl31 = 1'b1;
			7: sel.sltsl00 = 1'b1;
			8: sel.sltsl32 = 1'b1;
			default: sel.sltsl33 = 1'b1;
		endcase
		sel.sltsl0 = sel.sltsl00 | sel.sltsl01 | sel.sltsl02 | sel.sltsl03;
		sel.sltsl3 = sel.sltsl30 | sel.sltsl31 | sel.sltsl32 | sel.sltsl33;
		return sel;
	endfunction

	task automatic test_memory_map();
		int e0;
		logic [15:0] a;
		logic [7:0] seg;
		logic [7:0] wd;
		logic [21:0] m1;
		logic [21:0] m2;
		logic m1_rd;
		logic m2_rd;
		logic [9:0] hi;
		logic rd_ok;
		logic exp_rd_n;
		e0 = errors;
		for (int s = 0; s < 10; s++) begin
			for (int pg = 0; pg < 4; pg++) begin
				a = {pg[1:0], 14'(rand_bits(14))};
				seg = 8'(rand_bits(8));
				wd = 8'(rand_bits(8));
				m1 = 22'(rand_bits(22));
				m2 = 22'(rand_bits(22));
				m1_rd = 1'(rand_bits(1));
				m2_rd = 1'(rand_bits(1));
				@(posedge clk42m);
				slot_sel <= make_sel(s, pg[1:0]);
				cpu_bus <= '{addr: a, wdata: wd, mreq_n: 1'b0, iorq_n: 1'b1,
					rd_n: 1'b0, wr_n: 1'b0};
				// Bank chip select only for the slot under test
				rom_bank <= '{megarom1_addr: m1, megarom1_cs_n: (s != 1), megarom1_rd_n: m1_rd,
					megarom2_addr: m2, megarom2_cs_n: (s != 2), megarom2_rd_n: m2_rd,
					kanji_addr: '0, kanji_en: 1'b0, mapper_segment: seg};
				@(posedge clk42m);
				@(negedge clk42m);
				case (s)
					0: hi = msx_glue_pkg::MAP_MAPPER | {1'b0, seg, a[13]};
					1: hi = msx_glue_pkg::MAP_MEGA1 | {2'd0, m1[20:13]};
					2: hi = msx_glue_pkg::MAP_MEGA2 | {3'd0, m2[19:13]};
					3: hi = msx_glue_pkg::MAP_LOGO | {8'd0, a[14:13]};
					4: hi = msx_glue_pkg::MAP_MUSIC | {9'd0, a[13]};
					5: hi = msx_glue_pkg::MAP_BASICN | {9'd0, a[13]};
					6: hi = (pg == 0) ? (msx_glue_pkg::MAP_SUBROM | {9'd0, a[13]})
						: (msx_glue_pkg::MAP_KBASIC | {8'd0, a[15], a[13]});
					7: hi = msx_glue_pkg::MAP_MAIN | {8'd0, a[14:13]};
					8: hi = msx_glue_pkg::MAP_NEXTOR | {7'd0, a[15:13]};
					default: hi = '0;
				endcase
				// ROM pages that answer reads
				rd_ok = (s == 0) || (s == 6) || (s == 3 && (pg == 1 || pg == 2))
					|| ((s == 4 || s == 5) && pg == 1) || (s == 7 && pg < 2)
					|| (s == 8 && (pg == 1 || pg == 2));
				exp_rd_n = !rd_ok;
				if (s == 1) begin
					exp_rd_n = m1_rd;					// Mapper logic strobe
				end else if (s == 2) begin
					exp_rd_n = m2_rd;
				end
				check_value("sdram_req.addr", sdram_req.addr, {hi, a[12:0]});
				check_value("sdram_req.wdata", sdram_req.wdata, wd);
				check_value("sdram_req.mreq_n", sdram_req.mreq_n, 1'b0);
				check_value("sdram_req.rd_n", sdram_req.rd_n, exp_rd_n);
				check_value("sdram_req.wr_n", sdram_req.wr_n, s != 0);
			end
		end
		report_test("memory_map", e0);
	endtask

	// ------------------------------
	//	Loader and kanji override
	// ------------------------------
	task automatic test_overrides();
		int e0;
		logic [22:0] sa;
		logic [7:0] sd;
		logic [17:0] k;
		e0 = errors;
		sa = 23'(rand_bits(23));
		sd = 8'(rand_bits(8));
		@(posedge clk42m);
		cpu_freeze <= 1'b1;
		spi_req <= '{addr: sa, wdata: sd, mreq_n: 1'b0};
		@(posedge clk42m);
		@(negedge clk42m);
		check_value("sdram_req.addr", sdram_req.addr, sa);
		check_value("sdram_req.wdata", sdram_req.wdata, sd);
		check_value("sdram_req.mreq_n", sdram_req.mreq_n, 1'b0);
		check_value("sdram_req.wr_n", sdram_req.wr_n, 1'b0);
		check_value("sdram_req.rd_n", sdram_req.rd_n, 1'b1);
		k = 18'(rand_bits(18));
		@(posedge clk42m);
		cpu_freeze <= 1'b0;
		spi_req.mreq_n <= 1'b1;
		rom_bank.kanji_en <= 1'b1;
		rom_bank.kanji_addr <= k;
		@(posedge clk42m);
		@(negedge clk42m);
		check_value("sdram_req.addr", sdram_req.addr,
			{msx_glue_pkg::MAP_KANJI | {5'd0, k[17:13]}, k[12:0]});
		check_value("sdram_req.rd_n", sdram_req.rd_n, 1'b0);
		@(posedge clk42m);
		rom_bank.kanji_en <= 1'b0;
		report_test("overrides", e0);
	endtask

	// ------------------------------
	//	Read priority
	// ------------------------------
	task automatic test_read_priority();
		int e0;
		logic [7:0] d [6];
		logic [5:0] en;
		logic [7:0] exp;
		e0 = errors;
		for (int t = 0; t < 12; t++) begin
			for (int i = 0; i < 6; i++) begin
				d[i] = 8'(rand_bits(8));
			end
			en = 6'(rand_bits(6));
			if (t == 11) begin
				en = '0;						// Idle fill over a latched byte
			end
			exp = 8'hFF;						// rd_n high, idle fill
			for (int i = 5; i >= 0; i--) begin
				if (en[5-i]) begin
					exp = d[i];
				end
			end
			@(posedge clk42m);
			cpu_bus.rd_n <= 1'b1;
			rd_src <= {d[0], en[5], d[1], en[4], d[2], en[3], d[3], en[2],
				d[4], en[1], d[5], en[0]};
			@(posedge clk42m);
			rd_src <= '0;
			cpu_bus.rd_n <= 1'b0;
			@(negedge clk42m);
			check_value("cpu_rdata", cpu_rdata, exp);
			@(posedge clk42m);
			@(negedge clk42m);
			check_value("cpu_rdata held", cpu_rdata, exp);	// rd_n low, no source
		end
		report_test("read_priority", e0);
	endtask

	initial begin
		ff_reset0_n = 1'b0;
		cpu_bus = '{addr: 16'h0000, wdata: 8'h00, mreq_n: 1'b1, iorq_n: 1'b1,
			rd_n: 1'b1, wr_n: 1'b1};
		slot_sel = '0;
		rom_bank = '0;
		rom_bank.megarom1_cs_n = 1'b1;
		rom_bank.megarom2_cs_n = 1'b1;
		spi_req = '0;
		spi_req.mreq_n = 1'b1;
		cpu_freeze = 1'b0;
		sdram_init_busy = 1'b0;
		rd_src = '0;
		repeat (10) @(posedge clk42m);
		ff_reset0_n <= 1'b1;
		test_enables();
		test_io_decode();
		test_memory_map();
		test_overrides();
		test_read_priority();
		errors += dut0.u_bus_control.u_glue_assert.fail_count;	// Bound checker failures
		$display("Summary: %0d errors after %0d cycles", errors, cycles);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* msx_glue.f */
src/msx_glue_pkg.sv
src/msx_bus_control.sv
src/msx_memory_map.sv
src/msx_read_mux.sv
src/msx_glue_top.sv
tests/msx_glue_assert.sv
tests/msx_glue_tb.sv

/* Makefile */
# Verilator build and run of the bus glue testbench

VERILATOR	?= verilator
TOP			?= msx_glue_tb
FLIST		?= msx_glue.f
OBJ_DIR		?= obj_dir
LOG			?= sim.log
VFLAGS		?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
